// File: design/vdc_pkg.sv
// Shared definitions for the VDC display timing core.
// Register numbers, the live timing register bank and the video output word.
// Files refer to these by scoped names, vdc_pkg::name.

package vdc_pkg;

	// register numbers as seen by the CPU
	localparam int unsigned reg_ht_addr   = 0;    // horizontal total minus 1
	localparam int unsigned reg_hd_addr   = 1;    // horizontal displayed
	localparam int unsigned reg_hp_addr   = 2;    // hsync position
	localparam int unsigned reg_sync_addr = 3;    // vsync width / hsync width
	localparam int unsigned reg_vt_addr   = 4;    // vertical total rows minus 1
	localparam int unsigned reg_vd_addr   = 6;    // rows displayed
	localparam int unsigned reg_vp_addr   = 7;    // vsync row
	localparam int unsigned reg_ctv_addr  = 9;    // scanlines per row minus 1
	localparam int unsigned reg_cth_addr  = 22;   // pixels per column minus 1, high nibble
	localparam int unsigned reg_mode_addr = 25;   // attribute enable, pixel double
	localparam int unsigned reg_ai_addr   = 27;   // address increment per row
	localparam int unsigned reg_deb_addr  = 34;   // display enable begin
	localparam int unsigned reg_dee_addr  = 35;   // display enable end

	typedef struct packed {
		logic [7:0] ht;     // R0
		logic [7:0] hd;     // R1
		logic [7:0] hp;     // R2
		logic [3:0] hw;     // R3[3:0]
		logic [3:0] vw;     // R3[7:4]
		logic [7:0] vt;     // R4
		logic [7:0] vd;     // R6
		logic [7:0] vp;     // R7
		logic [4:0] ctv;    // R9[4:0]
		logic [3:0] cth;    // R22[7:4]
		logic       atr;    // R25[6]
		logic       dbl;    // R25[4]
		logic [7:0] ai;     // R27
		logic [7:0] deb;    // R34
		logic [7:0] dee;    // R35
	} vdc_regs_t;

	// power-up timing, 80 column NTSC-ish screen
	localparam vdc_regs_t regs_default = '{
		ht: 8'd126, hd: 8'd80, hp: 8'd102, hw: 4'd9, vw: 4'd4,
		vt: 8'd38, vd: 8'd25, vp: 8'd32, ctv: 5'd7, cth: 4'd7,
		atr: 1'b1, dbl: 1'b0, ai: 8'd0, deb: 8'd125, dee: 8'd100
	};

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       hblank;
		logic       vblank;
		logic       de;         // display enable, both axes
		logic       hvisible;   // inside the visible column window
		logic [7:0] col;
		logic [7:0] row;
	} vdc_video_t;

endpackage

// File: design/vdc_regfile.sv
// CPU side register file for the VDC timing registers.
// A write with wr high loads the addressed register on that clock edge.
// rdata follows addr combinationally; unused bits read as 1, unmapped as 0xFF.

`timescale 1ns/1ps

module vdc_regfile #(
	parameter int addr_width = 6
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr,
	input  logic [addr_width-1:0] addr,
	input  logic [7:0]            wdata,
	output logic [7:0]            rdata,
	output vdc_pkg::vdc_regs_t    regs
);

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= vdc_pkg::regs_default;                  // chip power-up values
		end else if (wr) begin
			case (addr)
				vdc_pkg::reg_ht_addr:   regs.ht <= wdata;
				vdc_pkg::reg_hd_addr:   regs.hd <= wdata;
				vdc_pkg::reg_hp_addr:   regs.hp <= wdata;
				vdc_pkg::reg_sync_addr: begin
					regs.vw <= wdata[7:4];
					regs.hw <= wdata[3:0];
				end
				vdc_pkg::reg_vt_addr:   regs.vt <= wdata;
				vdc_pkg::reg_vd_addr:   regs.vd <= wdata;
				vdc_pkg::reg_vp_addr:   regs.vp <= wdata;
				vdc_pkg::reg_ctv_addr:  regs.ctv <= wdata[4:0];
				vdc_pkg::reg_cth_addr:  regs.cth <= wdata[7:4];  // low nibble not kept
				vdc_pkg::reg_mode_addr: begin
					regs.atr <= wdata[6];
					regs.dbl <= wdata[4];
				end
				vdc_pkg::reg_ai_addr:   regs.ai <= wdata;
				vdc_pkg::reg_deb_addr:  regs.deb <= wdata;
				vdc_pkg::reg_dee_addr:  regs.dee <= wdata;
				default: ;                                      // unmapped, write ignored
			endcase
		end
	end

	// readback mux
	always_comb begin
		case (addr)
			vdc_pkg::reg_ht_addr:   rdata = regs.ht;
			vdc_pkg::reg_hd_addr:   rdata = regs.hd;
			vdc_pkg::reg_hp_addr:   rdata = regs.hp;
			vdc_pkg::reg_sync_addr: rdata = {regs.vw, regs.hw};
			vdc_pkg::reg_vt_addr:   rdata = regs.vt;
			vdc_pkg::reg_vd_addr:   rdata = regs.vd;
			vdc_pkg::reg_vp_addr:   rdata = regs.vp;
			vdc_pkg::reg_ctv_addr:  rdata = {3'b111, regs.ctv};
			vdc_pkg::reg_cth_addr:  rdata = {regs.cth, 4'hf};
			vdc_pkg::reg_mode_addr: rdata = {1'b1, regs.atr, 1'b1, regs.dbl, 4'hf};
			vdc_pkg::reg_ai_addr:   rdata = regs.ai;
			vdc_pkg::reg_deb_addr:  rdata = regs.deb;
			vdc_pkg::reg_dee_addr:  rdata = regs.dee;
			default:                rdata = 8'hff;              // open bus
		endcase
	end

	// a write to an unknown address would corrupt the whole timing bank
	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (reset) wr |-> !$isunknown(addr)
	) else $error("register write with unknown address");

endmodule

// File: design/vdc_signals_h.sv
// Horizontal timing of the VDC.
// Counts pixels inside a character column and columns inside a scanline,
// advancing only when enable is high. Produces hsync, hblank, horizontal
// display enable and the visible column window. hsync_start comes from the
// vertical block and is sampled at each column boundary.
// When deb equals dee the display enable takes a parity of the CPU data bus,
// as the real chip does.

`timescale 1ns/1ps

module vdc_signals_h (
	input  logic               clk,
	input  logic               reset,
	input  logic               enable,        // pixel clock enable
	input  logic [7:0]         db_in,         // CPU data bus, crude random source
	input  vdc_pkg::vdc_regs_t regs,
	input  logic               hsync_start,   // column boundary where hsync begins
	output logic               newcol,        // first pixel of a column
	output logic               endcol,        // last pixel of a column
	output logic [7:0]         col,           // current column
	output logic [3:0]         pixel,         // pixel within column
	output logic               hvisible,      // visible and enabled column
	output logic               hdispen,       // horizontal display enable
	output logic               hsync,
	output logic               hblank
);

	logic [3:0] hb_count;                         // hblank columns left
	logic       hviscol;                          // inside visible window
	logic [7:0] deb_adj;
	logic [7:0] dee_adj;
	logic       line_end;
	logic       vis_end;
	logic       db_parity;

	assign hblank   = |hb_count;
	assign hvisible = hviscol & hdispen;
	assign line_end = col == regs.ht;

	// inside the displayed span the chip shifts begin/end by 2, else by 1
	assign deb_adj = (regs.deb >= 8'd7 && {1'b0, regs.deb} < {1'b0, regs.hd} + 9'd7) ?
		regs.deb + 8'd2 : regs.deb + 8'd1;
	assign dee_adj = (regs.dee >= 8'd7 && {1'b0, regs.dee} < {1'b0, regs.hd} + 9'd7) ?
		regs.dee + 8'd2 : regs.dee + 8'd1;

	assign db_parity = db_in[0] ^ db_in[1] ^ db_in[5] ^ db_in[7];

	// window close point shifts with double width and attribute mode
	always_comb begin
		if (regs.dbl)
			vis_end = newcol && {1'b0, col} == {1'b0, regs.hd} + 9'd9;
		else if (|regs.ai && !regs.atr)
			vis_end = endcol && {1'b0, col} == {1'b0, regs.hd} + 9'd7;
		else
			vis_end = endcol && {1'b0, col} == {1'b0, regs.hd} + 9'd8;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			col      <= 8'd0;
			pixel    <= {3'b000, regs.dbl};           // double width skips pixel 0
			hsync    <= 1'b0;
			hb_count <= 4'd0;
			newcol   <= 1'b0;
			endcol   <= 1'b1;                         // first enable starts a column
			hviscol  <= 1'b0;
			hdispen  <= 1'b0;
		end else if (enable) begin
			newcol <= endcol;
			endcol <= pixel == regs.cth - 4'd1;      // registered, lands on last pixel

			if (endcol) begin
				pixel <= {3'b000, regs.dbl};
				if (line_end) begin
					col <= 8'd0;
					if (deb_adj >= regs.ht)
						hdispen <= 1'b1;              // begin past line end, wraps on
				end else begin
					col <= col + 8'd1;
				end

				if (col == 8'd8)
					hviscol <= 1'b1;                  // visible window opens

				if (deb_adj == dee_adj) begin
					if (col == deb_adj)
						hdispen <= db_parity;         // chip quirk, bus noise
				end else begin
					if (col == deb_adj)
						hdispen <= 1'b1;
					if (col == dee_adj)
						hdispen <= 1'b0;
				end

				hsync <= hsync_start;

				if (hsync_start)
					hb_count <= regs.hw >> regs.dbl;  // half as many wide columns
				else if (hblank)
					hb_count <= hb_count - 4'd1;
			end else begin
				pixel <= pixel + 4'd1;
			end

			if (vis_end)
				hviscol <= 1'b0;                      // visible window closes
		end
	end

	// vertical block and window logic both depend on this pairing
	a_newcol_follows: assert property (
		@(posedge clk) disable iff (reset)
		enable |=> newcol == $past(endcol)
	) else $error("newcol does not follow endcol by one enabled cycle");

endmodule

// File: design/vdc_signals_v.sv
// Vertical timing of the VDC.
// Detects the hsync column and issues hsync_start back to the horizontal
// block. Each hsync_start is one scanline: scanlines are counted inside a
// character row and rows inside a frame. vsync runs for vw scanlines from
// the start of row vp. vdispen is high while the row is below vd.

`timescale 1ns/1ps

module vdc_signals_v (
	input  logic               clk,
	input  logic               reset,
	input  logic               enable,        // pixel clock enable
	input  vdc_pkg::vdc_regs_t regs,
	input  logic               endcol,        // last pixel of a column
	input  logic [7:0]         col,           // current column
	output logic               hsync_start,   // one cycle, at hsync column end
	output logic [7:0]         row,           // character row in frame
	output logic               vsync,
	output logic               vblank,
	output logic               vdispen        // vertical display enable
);

	logic [4:0] line;                             // scanline inside row
	logic [3:0] vs_count;                         // vsync scanlines left
	logic [7:0] next_row;
	logic       row_end;
	logic [4:0] vs_lines;                         // scanlines seen while vsync high

	// only an enabled endcol counts, so the pulse lasts one clk
	assign hsync_start = enable & endcol & (col == regs.hp);

	assign row_end  = line == regs.ctv;
	assign next_row = (row == regs.vt) ? 8'd0 : row + 8'd1;  // frame wrap

	assign vsync   = |vs_count;
	assign vdispen = row < regs.vd;
	assign vblank  = ~vdispen;

	always_ff @(posedge clk) begin
		if (reset) begin
			line     <= 5'd0;
			row      <= 8'd0;
			vs_count <= 4'd0;
		end else if (hsync_start) begin
			if (row_end) begin
				line <= 5'd0;
				row  <= next_row;
			end else begin
				line <= line + 5'd1;
			end

			// entering row vp starts vsync, never retriggered while running
			if (row_end && next_row == regs.vp && !vsync)
				vs_count <= regs.vw;
			else if (vsync)
				vs_count <= vs_count - 4'd1;
		end
	end

	// scanlines counted as seen through the horizontal block's column timing
	always_ff @(posedge clk) begin
		if (reset || !vsync)
			vs_lines <= 5'd0;
		else if (hsync_start)
			vs_lines <= vs_lines + 5'd1;
	end

	a_vsync_max_width: assert property (
		@(posedge clk) disable iff (reset) vs_lines <= 5'd15
	) else $error("vsync lasted more than 15 scanlines");

endmodule

// File: design/vdc_video_out.sv
// Output stage of the VDC timing core.
// Merges the horizontal and vertical flags with the current column and row
// into one video word, registered once per clk for a fixed one cycle latency.

`timescale 1ns/1ps

module vdc_video_out (
	input  logic                clk,
	input  logic                reset,
	input  logic                hsync,
	input  logic                hblank,
	input  logic                hdispen,
	input  logic                hvisible,
	input  logic [7:0]          col,
	input  logic                vsync,
	input  logic                vblank,
	input  logic                vdispen,
	input  logic [7:0]          row,
	output vdc_pkg::vdc_video_t video
);

	vdc_pkg::vdc_video_t video_next;

	always_comb begin
		video_next.hsync    = hsync;
		video_next.vsync    = vsync;
		video_next.hblank   = hblank;
		video_next.vblank   = vblank;
		// pixels only inside both display windows and outside both blanks
		video_next.de       = hdispen & vdispen & ~hblank & ~vblank;
		video_next.hvisible = hvisible;
		video_next.col      = col;
		video_next.row      = row;
	end

	always_ff @(posedge clk) begin
		if (reset)
			video <= '0;                              // all flags low, col/row 0
		else
			video <= video_next;
	end

endmodule

// File: design/vdc_top.sv
// Top level of the VDC display timing core.
// CPU writes go to the register file; the horizontal and vertical blocks
// run from the register bank on pixel clock enables, and the output stage
// registers the combined video word.

`timescale 1ns/1ps

module vdc_top #(
	parameter int addr_width = 6
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  enable,     // pixel clock enable
	input  logic                  wr,         // register write strobe
	input  logic [addr_width-1:0] addr,
	input  logic [7:0]            wdata,
	output logic [7:0]            rdata,
	output vdc_pkg::vdc_video_t   video
);

	vdc_pkg::vdc_regs_t regs;
	logic       hsync_start;
	logic       endcol;
	logic [7:0] col;
	logic       hvisible;
	logic       hdispen;
	logic       hsync;
	logic       hblank;
	logic [7:0] row;
	logic       vsync;
	logic       vblank;
	logic       vdispen;

	vdc_regfile #(.addr_width(addr_width)) i_vdc_regfile (
		.clk, .reset, .wr, .addr, .wdata, .rdata, .regs
	);

	// wdata doubles as the data bus noise source
	vdc_signals_h i_vdc_signals_h (
		.clk, .reset, .enable, .db_in(wdata), .regs, .hsync_start,
		.newcol(), .endcol, .col, .pixel(), .hvisible, .hdispen, .hsync, .hblank
	);

	vdc_signals_v i_vdc_signals_v (
		.clk, .reset, .enable, .regs, .endcol, .col,
		.hsync_start, .row, .vsync, .vblank, .vdispen
	);

	vdc_video_out i_vdc_video_out (
		.clk, .reset, .hsync, .hblank, .hdispen, .hvisible, .col,
		.vsync, .vblank, .vdispen, .row, .video
	);

endmodule

// File: tests/vdc_model.svh
// Cycle model of the VDC timing rules, included into the testbench module.
// model_step is called once per clock with the inputs seen at that edge;
// afterwards m_video holds the word the DUT should show after that edge.

`ifndef VDC_MODEL_SVH
`define VDC_MODEL_SVH

vdc_pkg::vdc_regs_t  m_regs;                   // register bank as written
vdc_pkg::vdc_video_t m_video;                  // expected output word
int m_col;
int m_pixel;
int m_hb;                                      // hblank columns left
int m_line;
int m_row;
int m_vs;                                      // vsync scanlines left
bit m_hsync;
bit m_newcol;
bit m_endcol;
bit m_viscol;
bit m_hden;

// begin/end move by two inside the displayed span, by one elsewhere
function automatic int adjust_de(input int v);
	if (v >= 7 && v < int'(m_regs.hd) + 7)
		return (v + 2) % 256;
	return (v + 1) % 256;
endfunction

function automatic logic [7:0] readback(input logic [5:0] a);
	case (a)
		6'd0:    return m_regs.ht;
		6'd1:    return m_regs.hd;
		6'd2:    return m_regs.hp;
		6'd3:    return {m_regs.vw, m_regs.hw};
		6'd4:    return m_regs.vt;
		6'd6:    return m_regs.vd;
		6'd7:    return m_regs.vp;
		6'd9:    return {3'b111, m_regs.ctv};                 // unused bits read 1
		6'd22:   return {m_regs.cth, 4'hf};
		6'd25:   return {1'b1, m_regs.atr, 1'b1, m_regs.dbl, 4'hf};
		6'd27:   return m_regs.ai;
		6'd34:   return m_regs.deb;
		6'd35:   return m_regs.dee;
		default: return 8'hff;                               // nothing mapped here
	endcase
endfunction

task automatic model_write(input logic [5:0] a, input logic [7:0] d);
	case (a)
		6'd0:  m_regs.ht = d;
		6'd1:  m_regs.hd = d;
		6'd2:  m_regs.hp = d;
		6'd3: begin
			m_regs.vw = d[7:4];
			m_regs.hw = d[3:0];
		end
		6'd4:  m_regs.vt = d;
		6'd6:  m_regs.vd = d;
		6'd7:  m_regs.vp = d;
		6'd9:  m_regs.ctv = d[4:0];
		6'd22: m_regs.cth = d[7:4];
		6'd25: begin
			m_regs.atr = d[6];
			m_regs.dbl = d[4];
		end
		6'd27: m_regs.ai = d;
		6'd34: m_regs.deb = d;
		6'd35: m_regs.dee = d;
		default: ;
	endcase
endtask

task automatic model_reset();
	m_pixel  = int'(m_regs.dbl);                 // uses the bank before the reset edge
	m_col    = 0;
	m_hb     = 0;
	m_line   = 0;
	m_row    = 0;
	m_vs     = 0;
	m_hsync  = 1'b0;
	m_newcol = 1'b0;
	m_endcol = 1'b1;
	m_viscol = 1'b0;
	m_hden   = 1'b0;
	m_regs   = '{ht: 8'd126, hd: 8'd80, hp: 8'd102, hw: 4'd9, vw: 4'd4,
		vt: 8'd38, vd: 8'd25, vp: 8'd32, ctv: 5'd7, cth: 4'd7,
		atr: 1'b1, dbl: 1'b0, ai: 8'd0, deb: 8'd125, dee: 8'd100};
endtask

task automatic model_step(input logic rst, input logic en, input logic wr_i,
		input logic [5:0] a, input logic [7:0] d);
	int deb_a;
	int dee_a;
	int nxt_row;
	bit nxt_end;
	bit hs_start;
	bit vis_end;
	bit row_end;
	bit vs_on;
	if (rst) begin
		m_video = '0;
		model_reset();
	end else begin
		// output word is the state before this edge
		m_video.hsync    = m_hsync;
		m_video.vsync    = m_vs != 0;
		m_video.hblank   = m_hb != 0;
		m_video.vblank   = m_row >= int'(m_regs.vd);
		m_video.de       = m_hden && m_row < int'(m_regs.vd) && m_hb == 0;
		m_video.hvisible = m_viscol && m_hden;
		m_video.col      = 8'(m_col);
		m_video.row      = 8'(m_row);
		deb_a    = adjust_de(int'(m_regs.deb));
		dee_a    = adjust_de(int'(m_regs.dee));
		hs_start = en && m_endcol && m_col == int'(m_regs.hp);
		if (m_regs.dbl)
			vis_end = m_newcol && m_col == int'(m_regs.hd) + 9;
		else if (m_regs.ai != 8'd0 && !m_regs.atr)
			vis_end = m_endcol && m_col == int'(m_regs.hd) + 7;
		else
			vis_end = m_endcol && m_col == int'(m_regs.hd) + 8;
		if (hs_start) begin                       // one scanline done
			row_end = m_line == int'(m_regs.ctv);
			nxt_row = (m_row == int'(m_regs.vt)) ? 0 : (m_row + 1) % 256;
			vs_on   = m_vs != 0;
			m_line  = row_end ? 0 : (m_line + 1) % 32;
			if (row_end)
				m_row = nxt_row;
			if (row_end && nxt_row == int'(m_regs.vp) && !vs_on)
				m_vs = int'(m_regs.vw);
			else if (vs_on)
				m_vs = m_vs - 1;
		end
		if (en) begin
			nxt_end = m_pixel == (int'(m_regs.cth) + 15) % 16;
			if (m_endcol) begin
				if (m_col == int'(m_regs.ht) && deb_a >= int'(m_regs.ht))
					m_hden = 1'b1;                // begin past the line end
				if (m_col == 8)
					m_viscol = 1'b1;
				if (deb_a == dee_a) begin
					if (m_col == deb_a)
						m_hden = d[0] ^ d[1] ^ d[5] ^ d[7];   // bus noise
				end else if (m_col == deb_a) begin
					m_hden = 1'b1;
				end else if (m_col == dee_a) begin
					m_hden = 1'b0;
				end
				m_hsync = hs_start;
				if (hs_start)
					m_hb = int'(m_regs.hw) >> m_regs.dbl;
				else if (m_hb != 0)
					m_hb = m_hb - 1;
				m_col   = (m_col == int'(m_regs.ht)) ? 0 : (m_col + 1) % 256;
				m_pixel = int'(m_regs.dbl);
			end else begin
				m_pixel = (m_pixel + 1) % 16;
			end
			if (vis_end)
				m_viscol = 1'b0;
			m_newcol = m_endcol;
			m_endcol = nxt_end;
		end
		if (wr_i)
			model_write(a, d);                    // new values count from the next edge
	end
endtask

`endif

// File: tests/vdc_tb.sv
// Testbench for the VDC display timing core.
// Programs the timing registers with random values from a fixed seed and
// compares every DUT output with the cycle model on each clock, plus
// period and width checks derived from the register values.

`timescale 1ns/1ps

module vdc_tb;

	logic                clk = 1'b0;
	logic                reset;
	logic                enable;
	logic                wr;
	logic [5:0]          addr;
	logic [7:0]          wdata;
	logic [7:0]          rdata;
	vdc_pkg::vdc_video_t video;
	integer              seed = 32'h6007;
	int                  cycles = 0;          // ticks since start

	`include "vdc_model.svh"

	vdc_top #(.addr_width(6)) i_vdc_top (
		.clk, .reset, .enable, .wr, .addr, .wdata, .rdata, .video
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// one clock: step the model with the inputs of the last edge, then compare
	task automatic tick();
		@(negedge clk);
		cycles++;
		model_step(reset, enable, wr, addr, wdata);
		check_value("video.hsync", 32'(video.hsync), 32'(m_video.hsync));
		check_value("video.vsync", 32'(video.vsync), 32'(m_video.vsync));
		check_value("video.hblank", 32'(video.hblank), 32'(m_video.hblank));
		check_value("video.vblank", 32'(video.vblank), 32'(m_video.vblank));
		check_value("video.de", 32'(video.de), 32'(m_video.de));
		check_value("video.hvisible", 32'(video.hvisible), 32'(m_video.hvisible));
		check_value("video.col", 32'(video.col), 32'(m_video.col));
		check_value("video.row", 32'(video.row), 32'(m_video.row));
		check_value("rdata", 32'(rdata), 32'(readback(addr)));
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) tick();
		reset = 1'b0;
	endtask

	task automatic write_reg(input int a, input int d);
		wr    = 1'b1;
		addr  = 6'(a);
		wdata = 8'(d);
		tick();                                      // readback checked right after
		wr    = 1'b0;
	endtask

	function automatic logic select_flag(input int sel);
		case (sel)
			0:       return video.hsync;
			1:       return video.vsync;
			default: return video.hblank;
		endcase
	endfunction

	task automatic wait_level(input int sel, input logic level, input int limit);
		int n;
		n = 0;
		while (select_flag(sel) !== level) begin
			if (n == limit) begin
				$display("timed out waiting for video flag %0d to go %0b", sel, level);
				$display(">>> FAIL");
				$fatal(1, "wait timeout");
			end
			tick();
			n++;
		end
	endtask

	initial begin
		int ht;
		int cth;
		int hw;
		int dbl;
		int vt;
		int vw;
		int a;
		int t0;
		int line_len;
		int duty;
		bit frozen;
		vdc_pkg::vdc_video_t last;
		reset  = 1'b1;
		enable = 1'b0;
		wr     = 1'b0;
		addr   = '0;
		wdata  = '0;
		apply_reset();
		enable = 1'b1;

		for (a = 0; a < 64; a++)
			write_reg(a, $random(seed));             // unmapped ones must read 0xff
		apply_reset();

		// horizontal timing, small lines
		repeat (3) begin
			ht  = 10 + {$random(seed)} % 10;
			cth = 2 + {$random(seed)} % 6;
			hw  = 2 + {$random(seed)} % 6;
			dbl = {$random(seed)} % 2;
			write_reg(0, ht);
			write_reg(2, 2 + {$random(seed)} % (ht - 2));
			write_reg(3, 8'h40 | hw);
			write_reg(22, cth << 4);
			write_reg(25, 8'h40 | (dbl << 4));
			line_len = (ht + 1) * (cth + 1 - dbl);
			repeat (2) begin                          // col may run on to 255 first
				wait_level(0, 1'b0, 4000);
				wait_level(0, 1'b1, 4000);
			end
			t0 = cycles;
			wait_level(2, 1'b0, 1000);
			check_value("hblank length", cycles - t0, (hw >> dbl) * (cth + 1 - dbl));
			wait_level(0, 1'b1, 1000);
			check_value("hsync period", cycles - t0, line_len);
			t0 = cycles;
			wait_level(0, 1'b0, 1000);
			check_value("hsync width", cycles - t0, cth + 1 - dbl);
		end

		// display enable window
		repeat (4) begin
			write_reg(1, 4 + {$random(seed)} % (ht - 4));
			write_reg(27, {$random(seed)} % 2);
			write_reg(25, {$random(seed)} & 8'h50);
			write_reg(34, {$random(seed)} % (ht + 3));
			write_reg(35, {$random(seed)} % (ht + 3));
			repeat (2) begin
				wait_level(0, 1'b0, 1000);
				wait_level(0, 1'b1, 1000);
			end
		end
		for (a = 0; a < 2; a++) begin
			t0 = {$random(seed)} % (ht + 1);
			write_reg(34, t0);
			write_reg(35, t0);
			wdata = 8'(a);                           // parity of the bus equals a
			repeat (2) begin
				wait_level(0, 1'b0, 1000);
				wait_level(0, 1'b1, 1000);
			end
		end

		// vertical timing over two frames each
		write_reg(25, 8'h40);
		line_len = (ht + 1) * (cth + 1);
		repeat (2) begin
			vt = 3 + {$random(seed)} % 4;
			vw = 1 + {$random(seed)} % 4;
			write_reg(4, vt);
			write_reg(9, 1 + {$random(seed)} % 3);
			write_reg(7, {$random(seed)} % (vt + 1));
			write_reg(6, 1 + {$random(seed)} % vt);
			write_reg(3, (vw << 4) | hw);
			wait_level(1, 1'b0, 20000);
			wait_level(1, 1'b1, 250000);             // row past a shorter vt wraps at 255
			repeat (2) begin
				wait_level(1, 1'b0, 20000);
				wait_level(1, 1'b1, 20000);
				t0 = cycles;
				wait_level(1, 1'b0, 20000);
				check_value("vsync width", cycles - t0, vw * line_len);
			end
		end

		// pixel clock gating at random duty cycles
		repeat (3) begin
			duty = 1 + {$random(seed)} % 3;
			repeat (1000) begin
				frozen = !enable;                     // edge before the next one was idle
				last   = video;
				enable = ({$random(seed)} % 4) < duty;
				tick();
				if (frozen)
					check_value("video frozen", 32'(video), 32'(last));
			end
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+tests
design/vdc_pkg.sv
design/vdc_regfile.sv
design/vdc_signals_h.sv
design/vdc_signals_v.sv
design/vdc_video_out.sv
design/vdc_top.sv
tests/vdc_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = vdc_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
